// File: filelist.f
hw/decode_pkg.sv
hw/opcode_decoder.sv
hw/imm_gen.sv
hw/reg_file.sv
hw/hazard_unit.sv
hw/branch_target_buffer.sv
hw/gshare_predictor.sv
hw/decode_stage.sv
sim/decode_stage_assertions.sv
sim/decode_stage_tb.sv

// File: hw/branch_target_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module branch_target_buffer import decode_pkg::*; #(
  parameter int BTB_IDX_BITS = 4
) (
  input  logic  clk,
  input  logic  reset,
  input  xlen_t lookup_pc,
  input  logic  wr_en,
  input  xlen_t wr_pc,
  input  xlen_t wr_target,
  output logic  hit,
  output xlen_t target
);

  localparam int ENTRIES  = 2 ** BTB_IDX_BITS;
  localparam int TAG_LSB  = 2 + BTB_IDX_BITS;
  localparam int TAG_BITS = XLEN - TAG_LSB;

  logic                    valid   [ENTRIES];
  logic [TAG_BITS-1:0]     tags    [ENTRIES];
  xlen_t                   targets [ENTRIES];

  logic [BTB_IDX_BITS-1:0] rd_idx;
  logic [BTB_IDX_BITS-1:0] wr_idx;

  assign rd_idx = lookup_pc[2 +: BTB_IDX_BITS]; // word aligned pc
  assign wr_idx = wr_pc[2 +: BTB_IDX_BITS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < ENTRIES; i++) begin
        valid[i] <= 1'b0;
      end
    end else if (wr_en) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      tags[wr_idx]    <= wr_pc[XLEN-1:TAG_LSB];
      targets[wr_idx] <= wr_target;
    end
  end

  assign hit    = valid[rd_idx] && (tags[rd_idx] == lookup_pc[XLEN-1:TAG_LSB]);
  assign target = targets[rd_idx];

endmodule

`default_nettype wire

// File: hw/decode_pkg.sv
`default_nettype none

package decode_pkg;

  localparam int XLEN     = 32;
  localparam int NUM_REGS = 32;

  typedef logic [XLEN-1:0] xlen_t;    // data word or address
  typedef logic [31:0]     inst_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [1:0]      pht_ctr_t; // 2-bit saturating counter

  localparam pht_ctr_t PHT_RESET_VAL = 2'b01; // weakly not taken

  // major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // funct3 for alu ops, shared by the register and immediate forms
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SRL  = 3'b101; // also sra
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  localparam logic [2:0] F3_LW   = 3'b010;
  localparam logic [2:0] F3_SW   = 3'b010;
  localparam logic [2:0] F3_JALR = 3'b000;

  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000; // sub, sra, srai

  // OP_INVALID sits at zero so a cleared latch reads as invalid
  typedef enum logic [5:0] {
    OP_INVALID,
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA,
    OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_SLTIU, OP_SLLI, OP_SRLI, OP_SRAI,
    OP_LUI, OP_AUIPC, OP_LW, OP_SW, OP_JAL, OP_JALR,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU
  } op_e;

  typedef enum logic [2:0] {
    FMT_NONE, FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J
  } fmt_e;

  typedef enum logic [2:0] {
    IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
  } imm_e;

endpackage

`default_nettype wire

// File: hw/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage import decode_pkg::*; #(
  parameter int HIST_BITS    = 8,
  parameter int BTB_IDX_BITS = 4
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 fe_valid,
  input  inst_t                fe_inst,
  input  xlen_t                fe_pc,
  input  xlen_t                fe_pc_plus,
  input  reg_idx_t             agex_rd,
  input  reg_idx_t             mem_rd,
  input  reg_idx_t             wb_rd,
  input  logic                 agex_writes_rd,
  input  logic                 mem_writes_rd,
  input  logic                 agex_flush,
  input  logic                 wb_we,
  input  xlen_t                wb_data,
  input  logic                 bp_update,
  input  logic                 bp_taken,
  input  logic [HIST_BITS-1:0] bp_pht_idx,
  input  xlen_t                bp_pc,
  input  xlen_t                bp_target,
  output logic                 stall,
  output logic                 de_valid,
  output inst_t                de_inst,
  output xlen_t                de_pc,
  output xlen_t                de_pc_plus,
  output op_e                  de_op,
  output fmt_e                 de_fmt,
  output xlen_t                de_imm,
  output xlen_t                de_rs1_val,
  output xlen_t                de_rs2_val,
  output logic                 de_pred_taken,
  output logic [HIST_BITS-1:0] de_pht_idx,
  output logic                 de_btb_hit,
  output logic                 fe_pred_branch,
  output logic                 fe_pred_taken,
  output xlen_t                fe_pred_target
);

  op_e                  op;
  fmt_e                 fmt;
  imm_e                 imm_kind;
  reg_idx_t             rs1;
  reg_idx_t             rs2;
  logic                 uses_rs1;
  logic                 uses_rs2;
  logic                 is_branch;
  xlen_t                imm;
  xlen_t                rs1_val;
  xlen_t                rs2_val;
  logic [HIST_BITS-1:0] pht_idx;
  logic                 btb_hit;
  logic                 bubble;

  opcode_decoder u_dec (
    .inst(fe_inst), .op(op), .fmt(fmt), .imm_kind(imm_kind), .rs1(rs1), .rs2(rs2),
    .uses_rs1(uses_rs1), .uses_rs2(uses_rs2), .is_branch(is_branch)
  );

  imm_gen u_imm (.inst(fe_inst), .imm_kind(imm_kind), .imm(imm));

  reg_file u_rf (
    .clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2),
    .wr_idx(wb_rd), .wr_en(wb_we), .wr_data(wb_data),
    .rs1_val(rs1_val), .rs2_val(rs2_val)
  );

  hazard_unit u_haz (
    .rs1(rs1), .rs2(rs2), .agex_rd(agex_rd), .mem_rd(mem_rd),
    .uses_rs1(uses_rs1), .uses_rs2(uses_rs2),
    .agex_writes_rd(agex_writes_rd), .mem_writes_rd(mem_writes_rd),
    .fe_valid(fe_valid), .stall(stall)
  );

  gshare_predictor #(
    .HIST_BITS(HIST_BITS), .BTB_IDX_BITS(BTB_IDX_BITS)
  ) u_bp (
    .clk(clk), .reset(reset), .lookup_pc(fe_pc), .lookup_is_branch(is_branch),
    .update(bp_update), .update_taken(bp_taken), .update_pht_idx(bp_pht_idx),
    .update_pc(bp_pc), .update_target(bp_target),
    .pred_branch(fe_pred_branch), .pred_taken(fe_pred_taken), .pred_pht_idx(pht_idx),
    .btb_hit(btb_hit), .pred_target(fe_pred_target)
  );

  assign bubble = stall || agex_flush; // fetch holds its word while we stall

  always_ff @(posedge clk) begin
    if (reset || bubble) begin
      de_valid      <= 1'b0;
      de_inst       <= '0;
      de_pc         <= '0;
      de_pc_plus    <= '0;
      de_op         <= OP_INVALID;
      de_fmt        <= FMT_NONE;
      de_imm        <= '0;
      de_rs1_val    <= '0;
      de_rs2_val    <= '0;
      de_pred_taken <= 1'b0;
      de_pht_idx    <= '0;
      de_btb_hit    <= 1'b0;
    end else begin
      de_valid      <= fe_valid;
      de_inst       <= fe_inst;
      de_pc         <= fe_pc;
      de_pc_plus    <= fe_pc_plus;
      de_op         <= op;
      de_fmt        <= fmt;
      de_imm        <= imm;
      de_rs1_val    <= rs1_val;
      de_rs2_val    <= rs2_val;
      de_pred_taken <= fe_pred_taken; // carried to execute for the update
      de_pht_idx    <= pht_idx;
      de_btb_hit    <= btb_hit;
    end
  end

endmodule

`default_nettype wire

// File: hw/gshare_predictor.sv
`timescale 1ns/100ps
`default_nettype none

module gshare_predictor import decode_pkg::*; #(
  parameter int HIST_BITS    = 8,
  parameter int BTB_IDX_BITS = 4
) (
  input  logic                 clk,
  input  logic                 reset,
  input  xlen_t                lookup_pc,
  input  logic                 lookup_is_branch,
  input  logic                 update,
  input  logic                 update_taken,
  input  logic [HIST_BITS-1:0] update_pht_idx,
  input  xlen_t                update_pc,
  input  xlen_t                update_target,
  output logic                 pred_branch,
  output logic                 pred_taken,
  output logic [HIST_BITS-1:0] pred_pht_idx,
  output logic                 btb_hit,
  output xlen_t                pred_target
);

  localparam int PHT_ENTRIES = 2 ** HIST_BITS;

  pht_ctr_t             pht [PHT_ENTRIES];
  logic [HIST_BITS-1:0] ghr;        // global outcome history, newest in bit 0
  pht_ctr_t             upd_ctr;
  xlen_t                btb_target;

  assign pred_pht_idx = lookup_pc[2 +: HIST_BITS] ^ ghr;
  assign pred_taken   = pht[pred_pht_idx] >= 2'd2; // msb of the counter
  assign pred_branch  = lookup_is_branch;

  // only redirect when we know where to go
  assign pred_target  = (pred_taken && btb_hit) ? btb_target : lookup_pc + XLEN'(4);

  assign upd_ctr = pht[update_pht_idx];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < PHT_ENTRIES; i++) begin
        pht[i] <= PHT_RESET_VAL;
      end
      ghr <= '0;
    end else if (update) begin
      if (update_taken && upd_ctr != 2'd3) begin
        pht[update_pht_idx] <= upd_ctr + 2'd1;
      end else if (!update_taken && upd_ctr != 2'd0) begin
        pht[update_pht_idx] <= upd_ctr - 2'd1;
      end
      ghr <= {ghr[HIST_BITS-2:0], update_taken};
    end
  end

  branch_target_buffer #(
    .BTB_IDX_BITS(BTB_IDX_BITS)
  ) u_btb (
    .clk       (clk),
    .reset     (reset),
    .lookup_pc (lookup_pc),
    .wr_en     (update),        // every resolved branch refreshes its entry
    .wr_pc     (update_pc),
    .wr_target (update_target),
    .hit       (btb_hit),
    .target    (btb_target)
  );

endmodule

`default_nettype wire

// File: hw/hazard_unit.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_unit import decode_pkg::*; (
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  reg_idx_t agex_rd,
  input  reg_idx_t mem_rd,
  input  logic     uses_rs1,
  input  logic     uses_rs2,
  input  logic     agex_writes_rd,
  input  logic     mem_writes_rd,
  input  logic     fe_valid,
  output logic     stall
);

  logic rs1_raw;
  logic rs2_raw;

  // x0 never creates a dependency
  assign rs1_raw = uses_rs1 && rs1 != '0 &&
                   ((agex_writes_rd && agex_rd == rs1) || (mem_writes_rd && mem_rd == rs1));
  assign rs2_raw = uses_rs2 && rs2 != '0 &&
                   ((agex_writes_rd && agex_rd == rs2) || (mem_writes_rd && mem_rd == rs2));

  assign stall = fe_valid && (rs1_raw || rs2_raw);

endmodule

`default_nettype wire

// File: hw/imm_gen.sv
`timescale 1ns/100ps
`default_nettype none

module imm_gen import decode_pkg::*; (
  input  inst_t inst,
  input  imm_e  imm_kind,
  output xlen_t imm
);

  always_comb begin
    case (imm_kind)
      IMM_I:
        imm = {{20{inst[31]}}, inst[31:20]};
      IMM_S:
        imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      IMM_B: // offset in halfwords, lsb always zero
        imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      IMM_U:
        imm = {inst[31:12], 12'b0};
      IMM_J:
        imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      default:
        imm = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/opcode_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module opcode_decoder import decode_pkg::*; (
  input  inst_t    inst,
  output op_e      op,
  output fmt_e     fmt,
  output imm_e     imm_kind,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output logic     uses_rs1,
  output logic     uses_rs2,
  output logic     is_branch
);

  logic [6:0] opc;
  logic [2:0] f3;
  logic [6:0] f7;

  assign opc = inst[6:0];
  assign f3  = inst[14:12];
  assign f7  = inst[31:25];
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];

  always_comb begin
    op = OP_INVALID; // anything unmatched falls through
    case (opc)
      OPC_OP: begin
        if (f7 == F7_BASE) begin
          case (f3)
            F3_ADD:  op = OP_ADD;
            F3_SLL:  op = OP_SLL;
            F3_SLT:  op = OP_SLT;
            F3_SLTU: op = OP_SLTU;
            F3_XOR:  op = OP_XOR;
            F3_SRL:  op = OP_SRL;
            F3_OR:   op = OP_OR;
            default: op = OP_AND;
          endcase
        end else if (f7 == F7_SUB && f3 == F3_ADD) begin
          op = OP_SUB;
        end else if (f7 == F7_SUB && f3 == F3_SRL) begin
          op = OP_SRA;
        end
      end
      OPC_OP_IMM: begin
        case (f3)
          F3_ADD:  op = OP_ADDI;
          F3_SLT:  op = OP_SLTI;
          F3_SLTU: op = OP_SLTIU;
          F3_XOR:  op = OP_XORI;
          F3_OR:   op = OP_ORI;
          F3_AND:  op = OP_ANDI;
          F3_SLL:  op = (f7 == F7_BASE) ? OP_SLLI : OP_INVALID;
          default: op = (f7 == F7_BASE) ? OP_SRLI : (f7 == F7_SUB) ? OP_SRAI : OP_INVALID;
        endcase
      end
      OPC_LUI:   op = OP_LUI;
      OPC_AUIPC: op = OP_AUIPC;
      OPC_JAL:   op = OP_JAL;
      OPC_LOAD:  if (f3 == F3_LW)   op = OP_LW;
      OPC_STORE: if (f3 == F3_SW)   op = OP_SW;
      OPC_JALR:  if (f3 == F3_JALR) op = OP_JALR;
      OPC_BRANCH: begin
        case (f3)
          F3_BEQ:  op = OP_BEQ;
          F3_BNE:  op = OP_BNE;
          F3_BLT:  op = OP_BLT;
          F3_BGE:  op = OP_BGE;
          F3_BLTU: op = OP_BLTU;
          F3_BGEU: op = OP_BGEU;
          default: op = OP_INVALID;
        endcase
      end
      default: op = OP_INVALID;
    endcase
  end

  always_comb begin
    fmt = FMT_NONE;
    if (op inside {[OP_ADD:OP_SRA]})            fmt = FMT_R;
    else if (op inside {[OP_ADDI:OP_SRAI], OP_LW, OP_JALR}) fmt = FMT_I;
    else if (op == OP_SW)                       fmt = FMT_S;
    else if (op inside {[OP_BEQ:OP_BGEU]})      fmt = FMT_B;
    else if (op inside {OP_LUI, OP_AUIPC})      fmt = FMT_U;
    else if (op == OP_JAL)                      fmt = FMT_J;
  end

  always_comb begin
    case (fmt)
      FMT_I:   imm_kind = IMM_I;
      FMT_S:   imm_kind = IMM_S;
      FMT_B:   imm_kind = IMM_B;
      FMT_U:   imm_kind = IMM_U;
      FMT_J:   imm_kind = IMM_J;
      default: imm_kind = IMM_NONE; // R and invalid carry no immediate
    endcase
  end

  // U and J read no registers, so they never stall
  assign uses_rs1  = fmt inside {FMT_R, FMT_I, FMT_S, FMT_B};
  assign uses_rs2  = fmt inside {FMT_R, FMT_S, FMT_B};
  assign is_branch = (fmt == FMT_B);

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file import decode_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  reg_idx_t wr_idx,
  input  logic     wr_en,
  input  xlen_t    wr_data,
  output xlen_t    rs1_val,
  output xlen_t    rs2_val
);

  xlen_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_idx != '0) begin // x0 stays zero
      regs[wr_idx] <= wr_data;
    end
  end

  // same-cycle writeback is forwarded to the readers
  always_comb begin
    if (rs1 == '0)                      rs1_val = '0;
    else if (wr_en && wr_idx == rs1)    rs1_val = wr_data;
    else                                rs1_val = regs[rs1];

    if (rs2 == '0)                      rs2_val = '0;
    else if (wr_en && wr_idx == rs2)    rs2_val = wr_data;
    else                                rs2_val = regs[rs2];
  end

endmodule

`default_nettype wire

// File: sim/decode_stage_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage_checker import decode_pkg::*; #(
  parameter int HIST_BITS = 8
) (
  input logic                 clk,
  input logic                 reset,
  input logic                 stall,
  input logic                 de_valid,
  input inst_t                de_inst,
  input xlen_t                de_pc,
  input xlen_t                de_pc_plus,
  input op_e                  de_op,
  input fmt_e                 de_fmt,
  input xlen_t                de_imm,
  input xlen_t                de_rs1_val,
  input xlen_t                de_rs2_val,
  input logic                 de_pred_taken,
  input logic [HIST_BITS-1:0] de_pht_idx,
  input logic                 de_btb_hit,
  input logic                 fe_pred_branch,
  input logic                 fe_pred_taken,
  input xlen_t                fe_pred_target,
  input logic                 check_en,
  input string                test_name,
  input logic                 exp_stall,
  input logic                 exp_valid,
  input inst_t                exp_inst,
  input xlen_t                exp_pc,
  input xlen_t                exp_pc_plus,
  input op_e                  exp_op,
  input fmt_e                 exp_fmt,
  input xlen_t                exp_imm,
  input xlen_t                exp_rs1_val,
  input xlen_t                exp_rs2_val,
  input logic                 exp_pred_taken,
  input logic [HIST_BITS-1:0] exp_pht_idx,
  input logic                 exp_btb_hit,
  input logic                 exp_fe_branch,
  input logic                 exp_fe_taken,
  input xlen_t                exp_fe_target
);

  int fail_count = 0; // watched by the testbench

  a_stall: assert property (@(posedge clk) disable iff (reset) check_en |-> stall == exp_stall)
    else begin
      $error("ERR %s stall: expected %0b, actual %0b", test_name,
             $sampled(exp_stall), $sampled(stall));
      fail_count++;
    end

  a_valid: assert property (@(posedge clk) disable iff (reset) check_en |-> de_valid == exp_valid)
    else begin
      $error("ERR %s de_valid: expected %0b, actual %0b", test_name,
             $sampled(exp_valid), $sampled(de_valid));
      fail_count++;
    end

  // raw word and pc carried through the latch
  a_latch: assert property (@(posedge clk) disable iff (reset)
                            check_en |-> de_inst == exp_inst && de_pc == exp_pc &&
                                         de_pc_plus == exp_pc_plus)
    else begin
      $error("ERR %s latch: expected %h %h %h, actual %h %h %h", test_name,
             $sampled(exp_inst), $sampled(exp_pc), $sampled(exp_pc_plus),
             $sampled(de_inst), $sampled(de_pc), $sampled(de_pc_plus));
      fail_count++;
    end

  // op and format together
  a_decode: assert property (@(posedge clk) disable iff (reset)
                             check_en |-> de_op == exp_op && de_fmt == exp_fmt)
    else begin
      $error("ERR %s decode: expected op %0d fmt %0d, actual op %0d fmt %0d", test_name,
             $sampled(exp_op), $sampled(exp_fmt), $sampled(de_op), $sampled(de_fmt));
      fail_count++;
    end

  a_imm: assert property (@(posedge clk) disable iff (reset) check_en |-> de_imm == exp_imm)
    else begin
      $error("ERR %s de_imm: expected %h, actual %h", test_name,
             $sampled(exp_imm), $sampled(de_imm));
      fail_count++;
    end

  a_operands: assert property (@(posedge clk) disable iff (reset)
                               check_en |-> de_rs1_val == exp_rs1_val && de_rs2_val == exp_rs2_val)
    else begin
      $error("ERR %s operands: expected %h %h, actual %h %h", test_name,
             $sampled(exp_rs1_val), $sampled(exp_rs2_val),
             $sampled(de_rs1_val), $sampled(de_rs2_val));
      fail_count++;
    end

  a_fe_branch: assert property (@(posedge clk) disable iff (reset)
                                check_en |-> fe_pred_branch == exp_fe_branch)
    else begin
      $error("ERR %s fe_pred_branch: expected %0b, actual %0b", test_name,
             $sampled(exp_fe_branch), $sampled(fe_pred_branch));
      fail_count++;
    end

  // lookup seen by fetch in the same cycle
  a_fe_pred: assert property (@(posedge clk) disable iff (reset)
                              check_en |-> fe_pred_taken == exp_fe_taken &&
                                           fe_pred_target == exp_fe_target)
    else begin
      $error("ERR %s fetch prediction: expected %0b %h, actual %0b %h", test_name,
             $sampled(exp_fe_taken), $sampled(exp_fe_target),
             $sampled(fe_pred_taken), $sampled(fe_pred_target));
      fail_count++;
    end

  a_de_pred: assert property (@(posedge clk) disable iff (reset)
                              check_en |-> de_pred_taken == exp_pred_taken &&
                                           de_pht_idx == exp_pht_idx && de_btb_hit == exp_btb_hit)
    else begin
      $error("ERR %s latched prediction: expected %0b %h %0b, actual %0b %h %0b", test_name,
             $sampled(exp_pred_taken), $sampled(exp_pht_idx), $sampled(exp_btb_hit),
             $sampled(de_pred_taken), $sampled(de_pht_idx), $sampled(de_btb_hit));
      fail_count++;
    end

endmodule

`default_nettype wire

// File: sim/decode_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage_tb import decode_pkg::*; ();

  localparam int HIST_BITS  = 8;
  localparam int BTB_IDX    = 4;
  localparam int MAX_CYCLES = 2000;

  logic                 clk, reset;
  logic                 fe_valid, agex_writes_rd, mem_writes_rd, agex_flush, wb_we;
  inst_t                fe_inst;
  xlen_t                fe_pc, fe_pc_plus, wb_data, bp_pc, bp_target;
  reg_idx_t             agex_rd, mem_rd, wb_rd;
  logic                 bp_update, bp_taken;
  logic [HIST_BITS-1:0] bp_pht_idx;

  logic                 stall, de_valid, de_pred_taken, de_btb_hit;
  logic                 fe_pred_branch, fe_pred_taken;
  inst_t                de_inst;
  xlen_t                de_pc, de_pc_plus, de_imm, de_rs1_val, de_rs2_val, fe_pred_target;
  op_e                  de_op;
  fmt_e                 de_fmt;
  logic [HIST_BITS-1:0] de_pht_idx;

  // expected values handed to the checker
  logic                 check_en;
  string                test_name;
  logic                 exp_stall, exp_valid, exp_pred_taken, exp_btb_hit, exp_fe_taken;
  logic                 exp_fe_branch;
  inst_t                exp_inst;
  xlen_t                exp_pc, exp_pc_plus;
  op_e                  exp_op, cur_op;
  fmt_e                 exp_fmt, cur_fmt;
  xlen_t                exp_imm, exp_rs1_val, exp_rs2_val, exp_fe_target, cur_imm;
  logic [HIST_BITS-1:0] exp_pht_idx;
  logic                 cur_use1, cur_use2;

  // reference state of the register file and predictor
  xlen_t                  ref_regs [NUM_REGS];
  pht_ctr_t               ref_pht [2**HIST_BITS];
  logic [HIST_BITS-1:0]   ref_ghr;
  logic                   btb_valid [2**BTB_IDX];
  logic [31:2+BTB_IDX]    btb_tag [2**BTB_IDX];
  xlen_t                  btb_tgt [2**BTB_IDX];

  xlen_t pc_pool [4];
  op_e   kinds [8];
  int    cycle_count = 0;

  decode_stage UUT (.*);

  bind decode_stage decode_stage_checker #(.HIST_BITS(HIST_BITS)) u_chk (
    .clk, .reset, .stall, .de_valid, .de_op, .de_fmt, .de_imm, .de_rs1_val, .de_rs2_val,
    .de_pred_taken, .de_pht_idx, .de_btb_hit, .fe_pred_taken, .fe_pred_target,
    .de_inst, .de_pc, .de_pc_plus, .fe_pred_branch,
    .check_en(decode_stage_tb.check_en), .test_name(decode_stage_tb.test_name),
    .exp_stall(decode_stage_tb.exp_stall), .exp_valid(decode_stage_tb.exp_valid),
    .exp_inst(decode_stage_tb.exp_inst), .exp_pc(decode_stage_tb.exp_pc),
    .exp_pc_plus(decode_stage_tb.exp_pc_plus),
    .exp_op(decode_stage_tb.exp_op), .exp_fmt(decode_stage_tb.exp_fmt),
    .exp_imm(decode_stage_tb.exp_imm), .exp_rs1_val(decode_stage_tb.exp_rs1_val),
    .exp_rs2_val(decode_stage_tb.exp_rs2_val), .exp_pred_taken(decode_stage_tb.exp_pred_taken),
    .exp_pht_idx(decode_stage_tb.exp_pht_idx), .exp_btb_hit(decode_stage_tb.exp_btb_hit),
    .exp_fe_branch(decode_stage_tb.exp_fe_branch),
    .exp_fe_taken(decode_stage_tb.exp_fe_taken), .exp_fe_target(decode_stage_tb.exp_fe_target)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: no verdict after %0d cycles", MAX_CYCLES);
      $display("test failed");
      $fatal(1, "timeout");
    end
  end

  initial begin
    wait (UUT.u_chk.fail_count != 0);
    $display("test failed");
    $fatal(1, "stopped at the first failed check");
  end

  function automatic logic depends_on(reg_idx_t r);
    return r != '0 && ((agex_writes_rd && agex_rd == r) || (mem_writes_rd && mem_rd == r));
  endfunction

  function automatic xlen_t read_ref_reg(reg_idx_t r);
    if (r == '0) return '0;
    if (wb_we && wb_rd == r) return wb_data; // written this cycle
    return ref_regs[r];
  endfunction

  task automatic put_pc(input xlen_t pc);
    fe_pc      = pc;
    fe_pc_plus = pc + 32'd4;
  endtask

  // builds an RV32I word from its fields and notes what decode should give
  task automatic encode_word(input op_e op, input reg_idx_t s1, input reg_idx_t s2);
    reg_idx_t rd;
    xlen_t    r;
    rd       = reg_idx_t'($urandom);
    r        = $urandom;
    cur_op   = op;
    cur_use1 = 1'b1;
    cur_use2 = 1'b1;
    cur_imm  = '0;
    case (op)
      OP_ADD, OP_SUB: begin
        fe_inst = {((op == OP_SUB) ? F7_SUB : F7_BASE), s2, s1, F3_ADD, rd, OPC_OP};
        cur_fmt = FMT_R;
      end
      OP_ADDI: begin
        fe_inst  = {r[11:0], s1, F3_ADD, rd, OPC_OP_IMM};
        cur_fmt  = FMT_I;
        cur_imm  = {{20{r[11]}}, r[11:0]};
        cur_use2 = 1'b0;
      end
      OP_SW: begin
        fe_inst = {r[11:5], s2, s1, F3_SW, r[4:0], OPC_STORE};
        cur_fmt = FMT_S;
        cur_imm = {{20{r[11]}}, r[11:0]};
      end
      OP_BEQ: begin
        fe_inst = {r[12], r[10:5], s2, s1, F3_BEQ, r[4:1], r[11], OPC_BRANCH};
        cur_fmt = FMT_B;
        cur_imm = {{19{r[12]}}, r[12:1], 1'b0};
      end
      OP_LUI: begin
        fe_inst = {r[31:12], rd, OPC_LUI};
        cur_fmt = FMT_U;
        cur_imm = {r[31:12], 12'b0};
      end
      OP_JAL: begin
        fe_inst = {r[20], r[10:1], r[11], r[19:12], rd, OPC_JAL};
        cur_fmt = FMT_J;
        cur_imm = {{11{r[20]}}, r[20:1], 1'b0};
      end
      default: begin
        fe_inst = '1; // opcode 1111111 is outside RV32I
        cur_op  = OP_INVALID;
        cur_fmt = FMT_NONE;
      end
    endcase
    if (cur_fmt inside {FMT_U, FMT_J, FMT_NONE}) begin
      cur_use1 = 1'b0;
      cur_use2 = 1'b0;
    end
  endtask

  // sets expectations for the inputs now driven, then moves the models across one edge
  task automatic advance_cycle();
    logic [HIST_BITS-1:0] idx;
    logic [BTB_IDX-1:0]   bi, wi;
    logic                 hit, bubble;
    xlen_t                n_rs1, n_rs2;
    pht_ctr_t             ctr;
    exp_stall = fe_valid && ((cur_use1 && depends_on(fe_inst[19:15])) ||
                             (cur_use2 && depends_on(fe_inst[24:20])));
    exp_fe_branch = (cur_fmt == FMT_B);
    idx = fe_pc[2 +: HIST_BITS] ^ ref_ghr; // gshare index
    bi  = fe_pc[2 +: BTB_IDX];
    hit = btb_valid[bi] && btb_tag[bi] == fe_pc[31:2+BTB_IDX];
    exp_fe_taken  = ref_pht[idx][1];
    exp_fe_target = (exp_fe_taken && hit) ? btb_tgt[bi] : fe_pc + 32'd4;
    bubble = exp_stall || agex_flush;
    n_rs1  = read_ref_reg(fe_inst[19:15]);
    n_rs2  = read_ref_reg(fe_inst[24:20]);
    if (wb_we && wb_rd != '0) ref_regs[wb_rd] = wb_data;
    if (bp_update) begin
      ctr = ref_pht[bp_pht_idx];
      if (bp_taken && ctr != 2'd3) ref_pht[bp_pht_idx] = ctr + 2'd1;
      if (!bp_taken && ctr != 2'd0) ref_pht[bp_pht_idx] = ctr - 2'd1;
      ref_ghr = {ref_ghr[HIST_BITS-2:0], bp_taken};
      wi = bp_pc[2 +: BTB_IDX];
      btb_valid[wi] = 1'b1;
      btb_tag[wi]   = bp_pc[31:2+BTB_IDX];
      btb_tgt[wi]   = bp_target;
    end
    @(posedge clk);
    #1;
    exp_valid      = !bubble && fe_valid;
    exp_inst       = bubble ? '0 : fe_inst; // fetch inputs still hold this cycle's word
    exp_pc         = bubble ? '0 : fe_pc;
    exp_pc_plus    = bubble ? '0 : fe_pc_plus;
    exp_op         = bubble ? OP_INVALID : cur_op;
    exp_fmt        = bubble ? FMT_NONE : cur_fmt;
    exp_imm        = bubble ? '0 : cur_imm;
    exp_rs1_val    = bubble ? '0 : n_rs1;
    exp_rs2_val    = bubble ? '0 : n_rs2;
    exp_pred_taken = !bubble && exp_fe_taken;
    exp_pht_idx    = bubble ? '0 : idx;
    exp_btb_hit    = !bubble && hit;
  endtask

  initial begin
    reg_idx_t wr_reg;
    void'($urandom(34));
    pc_pool = '{32'h0000_1000, 32'h0000_1004, 32'h0000_2000, 32'h0000_1038}; // 1000/2000 alias
    kinds   = '{OP_ADD, OP_SUB, OP_ADDI, OP_LUI, OP_SW, OP_BEQ, OP_JAL, OP_INVALID};
    reset          = 1'b1;
    check_en       = 1'b0;
    test_name      = "reset";
    fe_valid       = 1'b0;
    agex_rd        = '0;
    mem_rd         = '0;
    wb_rd          = '0;
    agex_writes_rd = 1'b0;
    mem_writes_rd  = 1'b0;
    agex_flush     = 1'b0;
    wb_we          = 1'b0;
    wb_data        = '0;
    bp_update      = 1'b0;
    bp_taken       = 1'b0;
    bp_pht_idx     = '0;
    bp_pc          = '0;
    bp_target      = '0;
    put_pc('0);
    encode_word(OP_INVALID, '0, '0);
    foreach (ref_regs[i]) ref_regs[i] = '0;
    foreach (ref_pht[i]) ref_pht[i] = PHT_RESET_VAL;
    foreach (btb_valid[i]) btb_valid[i] = 1'b0;
    ref_ghr        = '0;
    exp_valid      = 1'b0;
    exp_inst       = '0;
    exp_pc         = '0;
    exp_pc_plus    = '0;
    exp_op         = OP_INVALID;
    exp_fmt        = FMT_NONE;
    exp_imm        = '0;
    exp_rs1_val    = '0;
    exp_rs2_val    = '0;
    exp_pred_taken = 1'b0;
    exp_pht_idx    = '0;
    exp_btb_hit    = 1'b0;
    exp_fe_branch  = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    reset    = 1'b0;
    check_en = 1'b1;

    repeat (4) begin
      put_pc($urandom & ~32'h3);
      advance_cycle();
    end

    test_name = "decode";
    fe_valid  = 1'b1;
    repeat (5) begin
      foreach (kinds[k]) begin
        put_pc($urandom & ~32'h3);
        encode_word(kinds[k], reg_idx_t'($urandom), reg_idx_t'($urandom));
        advance_cycle();
      end
    end

    test_name = "regfile";
    wb_we     = 1'b1;
    repeat (6) begin
      wr_reg  = reg_idx_t'($urandom % 31 + 1);
      wb_rd   = wr_reg;
      wb_data = $urandom;
      encode_word(OP_ADD, '0, '0);
      advance_cycle();
      wb_data = $urandom; // read while rewritten
      encode_word(OP_SW, wr_reg, wr_reg);
      advance_cycle();
      wb_rd   = '0;
      wb_data = $urandom;
      encode_word(OP_BEQ, wr_reg, '0);
      advance_cycle();
    end
    wb_we = 1'b0;

    test_name = "hazard";
    repeat (40) begin
      agex_rd        = reg_idx_t'($urandom % 4);
      mem_rd         = reg_idx_t'($urandom % 4);
      agex_writes_rd = $urandom % 2;
      mem_writes_rd  = $urandom % 2;
      agex_flush     = ($urandom % 5 == 0);
      if (!exp_stall) begin // fetch holds its word through a stall
        put_pc($urandom & ~32'h3);
        encode_word(kinds[$urandom % 8], reg_idx_t'($urandom % 4), reg_idx_t'($urandom % 4));
      end
      advance_cycle();
    end
    agex_writes_rd = 1'b0;
    mem_writes_rd  = 1'b0;
    agex_flush     = 1'b0;

    // mostly taken, then mostly not taken, to drive counters to 3 and to 0
    test_name = "predictor";
    for (int phase = 0; phase < 2; phase++) begin
      repeat (40) begin
        put_pc(pc_pool[$urandom % 4]);
        encode_word(OP_BEQ, reg_idx_t'($urandom), reg_idx_t'($urandom));
        bp_update  = ($urandom % 8 != 0);
        bp_taken   = (phase == 0) ? ($urandom % 8 != 0) : ($urandom % 8 == 0);
        bp_pht_idx = fe_pc[2 +: HIST_BITS] ^ ref_ghr; // train the entry being looked up
        bp_pc      = pc_pool[$urandom % 4];
        bp_target  = $urandom & ~32'h3;
        advance_cycle();
      end
    end
    bp_update = 1'b0;
    advance_cycle();
    @(posedge clk);
    #1;
    if (UUT.u_chk.fail_count == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("test failed");
      $fatal(1, "assertion failures seen");
    end
  end

endmodule

`default_nettype wire
